// ==== compile.f ====
+incdir+.
pim_cmd_pkg.sv
pim_bus_pkg.sv
pim_dma_cmd_regs.sv
pim_dma_ctrl.sv
pim_dma_port_mux.sv
pim_dma_top.sv
tb_pim_dma.sv

// ==== pim_bus_pkg.sv ====
`default_nettype none

`include "pim_dma_params.svh"

package pim_bus_pkg;

    // engine phases
    typedef enum logic [2:0] {
        IDLE   = 3'd0,
        SETUP  = 3'd1,  // poll pim status
        MODE   = 3'd2,  // write opcode to mode reg
        FETCH  = 3'd3,  // first read of a transfer
        STREAM = 3'd4,  // sram to pim, one word per granted cycle
        WRITE  = 3'd5   // single closing write
    } pim_phase_e;

    // one request on a memory port, all zero when idle
    typedef struct packed {
        logic [`PIM_DMA_AW-1:0]  addr;
        logic                    we;
        logic                    re;
        logic [`PIM_DMA_DW-1:0]  wdata;
    } bus_port_t;

    // status word bits
    localparam int STATUS_VALID_BIT = 0;
    localparam int STATUS_DATA_BIT  = 1;

    // word step for sram addresses
    localparam logic [`PIM_DMA_AW-1:0] WORD_STEP = 4;

endpackage

`default_nettype wire

// ==== pim_cmd_pkg.sv ====
`default_nettype none

`include "pim_dma_params.svh"

package pim_cmd_pkg;

    // funct3 encodings, 0/6/7 are not supported
    typedef enum logic [2:0] {
        ERASE    = 3'd1,
        PROGRAM  = 3'd2,
        READ     = 3'd3,
        ZP       = 3'd4,
        PARALLEL = 3'd5
    } pim_op_e;

    // command as held for the whole transfer
    typedef struct packed {
        pim_op_e                 op;
        logic [`PIM_DMA_AW-1:0]  addr;  // row/col from rs1
        logic [`PIM_DMA_DW-1:0]  arg;   // timing, zp, read dest or parallel src
    } pim_cmd_t;

    function automatic logic op_supported(input logic [2:0] code);
        case (code)
            ERASE, PROGRAM, READ, ZP, PARALLEL: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // number of data beats for an opcode
    function automatic logic [4:0] op_beats(input pim_op_e op);
        return (op == PARALLEL) ? 5'(`PIM_PARALLEL_BEATS) : 5'd1;
    endfunction

endpackage

`default_nettype wire

// ==== pim_dma_cmd_regs.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "pim_dma_params.svh"

module pim_dma_cmd_regs (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    capture_i,
    input  logic [2:0]              funct3_i,
    input  logic [`PIM_DMA_AW-1:0]  rs1_i,
    input  logic [`PIM_DMA_DW-1:0]  rs2_i,
    input  logic                    load_beats_i,
    input  logic                    advance_i,
    output pim_cmd_pkg::pim_cmd_t   cmd_o,
    output logic [`PIM_DMA_AW-1:0]  mem_addr_o,
    output logic [4:0]              beats_left_o
);

    import pim_cmd_pkg::*;
    import pim_bus_pkg::*;

    pim_cmd_t                cmd_q;
    logic [`PIM_DMA_AW-1:0]  mem_addr_q;
    logic [4:0]              beats_q;

    // command fields only change on capture
    always_ff @(posedge clk_i) begin
        if (capture_i) begin
            cmd_q.op   <= pim_op_e'(funct3_i);
            cmd_q.addr <= rs1_i;
            cmd_q.arg  <= rs2_i;
        end
    end

    // sram pointer for parallel, starts at rs2
    always_ff @(posedge clk_i) begin
        if (capture_i) begin
            mem_addr_q <= rs2_i;
        end else if (advance_i) begin
            mem_addr_q <= mem_addr_q + WORD_STEP;
        end
    end

    // beat counter
    // load wins over advance, which keeps the count full while the
    // first parallel word is fetched
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            beats_q <= '0;
        end else if (load_beats_i) begin
            beats_q <= op_beats(cmd_q.op);
        end else if (advance_i) begin
            beats_q <= beats_q - 5'd1;
        end
    end

    assign cmd_o        = cmd_q;
    assign mem_addr_o   = mem_addr_q;
    assign beats_left_o = beats_q;

endmodule

`default_nettype wire

// ==== pim_dma_ctrl.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "pim_dma_params.svh"

module pim_dma_ctrl (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     dma_en_i,
    input  logic [2:0]               funct3_i,
    input  logic                     bus_gnt_i,
    input  logic [`PIM_DMA_DW-1:0]   pim_rd_data_i,
    input  pim_cmd_pkg::pim_cmd_t    cmd_i,
    input  logic [4:0]               beats_left_i,
    output pim_bus_pkg::pim_phase_e  phase_o,
    output logic                     capture_o,
    output logic                     load_beats_o,
    output logic                     advance_o,
    output logic                     fire_o,
    output logic                     bus_req_o,
    output logic                     dma_busy_o
);

    import pim_cmd_pkg::*;
    import pim_bus_pkg::*;

    pim_phase_e  phase_q;
    pim_phase_e  phase_nxt;
    logic        status_pend_q;
    logic        status_ok;
    logic        fire;

    // engine owns the bus in every phase but idle
    assign dma_busy_o = (phase_q != IDLE);
    assign bus_req_o  = dma_busy_o;
    assign fire       = bus_gnt_i && dma_busy_o;

    // read needs the data-valid bit on top of valid
    assign status_ok = pim_rd_data_i[STATUS_VALID_BIT] &&
                       ((cmd_i.op != READ) || pim_rd_data_i[STATUS_DATA_BIT]);

    always_comb begin
        phase_nxt    = phase_q;
        capture_o    = 1'b0;
        load_beats_o = 1'b0;
        advance_o    = 1'b0;
        case (phase_q)
            IDLE: begin
                if (dma_en_i && op_supported(funct3_i)) begin
                    capture_o = 1'b1;
                    phase_nxt = SETUP;
                end
            end
            SETUP: begin
                // rd data is only the status word if we asked for it last
                if (fire && status_pend_q && status_ok) begin
                    phase_nxt = MODE;
                end
            end
            MODE: begin
                if (fire) begin
                    load_beats_o = 1'b1;
                    case (cmd_i.op)
                        READ, PARALLEL: phase_nxt = FETCH;
                        default:        phase_nxt = WRITE;
                    endcase
                end
            end
            FETCH: begin
                if (fire) begin
                    if (cmd_i.op == PARALLEL) begin
                        load_beats_o = 1'b1;
                        advance_o    = 1'b1;
                        phase_nxt    = STREAM;
                    end else begin
                        phase_nxt = WRITE;
                    end
                end
            end
            STREAM: begin
                if (fire) begin
                    advance_o = 1'b1;
                    if (beats_left_i == 5'd1) begin
                        phase_nxt = IDLE;
                    end
                end
            end
            WRITE: begin
                if (fire) begin
                    phase_nxt = IDLE;
                end
            end
            default: phase_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            phase_q       <= IDLE;
            status_pend_q <= 1'b0;
        end else begin
            phase_q <= phase_nxt;
            if (fire) begin
                // a status read is in flight only if we stay in setup
                status_pend_q <= (phase_q == SETUP) && (phase_nxt == SETUP);
            end
        end
    end

    assign phase_o = phase_q;
    assign fire_o  = fire;

endmodule

`default_nettype wire

// ==== pim_dma_params.svh ====
`ifndef PIM_DMA_PARAMS_SVH
`define PIM_DMA_PARAMS_SVH

// pim macro bus map
`define PIM_BASE_ADDR       32'h4000_0000
`define PIM_MODE_ADDR       32'h4100_0000
`define PIM_ZP_ADDR         32'h4200_0000
`define PIM_STATUS_ADDR     32'h4300_0000

// bus widths, shared by both ports
`define PIM_DMA_AW          32
`define PIM_DMA_DW          32

// parallel transfer shape
`define PIM_PARALLEL_BEATS  16
// beat index sits in addr[15:12]
`define PIM_BEAT_SHIFT      12

`endif

// ==== pim_dma_port_mux.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "pim_dma_params.svh"

module pim_dma_port_mux (
    input  pim_bus_pkg::pim_phase_e  phase_i,
    input  logic                     fire_i,
    input  pim_cmd_pkg::pim_cmd_t    cmd_i,
    input  logic [`PIM_DMA_AW-1:0]   mem_addr_i,
    input  logic [4:0]               beats_left_i,
    input  logic [`PIM_DMA_DW-1:0]   sram_rd_data_i,
    input  logic [`PIM_DMA_DW-1:0]   pim_rd_data_i,
    output pim_bus_pkg::bus_port_t   sram_o,
    output pim_bus_pkg::bus_port_t   pim_o
);

    import pim_cmd_pkg::*;
    import pim_bus_pkg::*;

    logic [`PIM_DMA_AW-1:0]  row_addr;
    logic [3:0]              beat_idx;
    logic [`PIM_DMA_AW-1:0]  beat_addr;
    logic [`PIM_DMA_AW-1:0]  write_addr;
    logic [`PIM_DMA_DW-1:0]  write_data;

    assign row_addr = `PIM_BASE_ADDR + cmd_i.addr;

    // beat k counts up from 0 as the counter runs down
    assign beat_idx  = 4'(`PIM_PARALLEL_BEATS - beats_left_i);
    assign beat_addr = row_addr |
                       ({{(`PIM_DMA_AW-4){1'b0}}, beat_idx} << `PIM_BEAT_SHIFT);

    // closing pim write target and data
    always_comb begin
        case (cmd_i.op)
            ZP: begin
                write_addr = `PIM_ZP_ADDR;
                write_data = cmd_i.arg;
            end
            READ: begin
                // lands in sram at rs2
                write_addr = cmd_i.arg;
                write_data = pim_rd_data_i;
            end
            default: begin
                // erase / program timing word
                write_addr = row_addr;
                write_data = cmd_i.arg;
            end
        endcase
    end

    always_comb begin
        sram_o = '0;
        pim_o  = '0;
        if (fire_i) begin
            case (phase_i)
                SETUP: begin
                    pim_o.addr = `PIM_STATUS_ADDR;
                    pim_o.re   = 1'b1;
                end
                MODE: begin
                    pim_o.addr  = `PIM_MODE_ADDR;
                    pim_o.we    = 1'b1;
                    pim_o.wdata = {{(`PIM_DMA_DW-3){1'b0}}, cmd_i.op};
                end
                FETCH: begin
                    if (cmd_i.op == PARALLEL) begin
                        sram_o.addr = mem_addr_i;
                        sram_o.re   = 1'b1;
                    end else begin
                        pim_o.addr = row_addr;
                        pim_o.re   = 1'b1;
                    end
                end
                STREAM: begin
                    pim_o.addr  = beat_addr;
                    pim_o.we    = 1'b1;
                    pim_o.wdata = sram_rd_data_i;
                    // prefetch next word unless this is the last beat
                    if (beats_left_i > 5'd1) begin
                        sram_o.addr = mem_addr_i;
                        sram_o.re   = 1'b1;
                    end
                end
                WRITE: begin
                    if (cmd_i.op == READ) begin
                        sram_o.addr  = write_addr;
                        sram_o.we    = 1'b1;
                        sram_o.wdata = write_data;
                    end else begin
                        pim_o.addr  = write_addr;
                        pim_o.we    = 1'b1;
                        pim_o.wdata = write_data;
                    end
                end
                default: begin
                    sram_o = '0;
                    pim_o  = '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== pim_dma_top.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "pim_dma_params.svh"

module pim_dma_top (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    // command from the core
    input  logic                    dma_en_i,
    input  logic [2:0]              funct3_i,
    input  logic [`PIM_DMA_AW-1:0]  rs1_i,
    input  logic [`PIM_DMA_DW-1:0]  rs2_i,
    // shared bus arbitration
    output logic                    bus_req_o,
    input  logic                    bus_gnt_i,
    // memory ports
    output pim_bus_pkg::bus_port_t  sram_o,
    input  logic [`PIM_DMA_DW-1:0]  sram_rd_data_i,
    output pim_bus_pkg::bus_port_t  pim_o,
    input  logic [`PIM_DMA_DW-1:0]  pim_rd_data_i,
    output logic                    dma_busy_o
);

    import pim_cmd_pkg::*;
    import pim_bus_pkg::*;

    pim_cmd_t                cmd;
    logic [`PIM_DMA_AW-1:0]  mem_addr;
    logic [4:0]              beats_left;
    pim_phase_e              phase;
    logic                    capture;
    logic                    load_beats;
    logic                    advance;
    logic                    fire;

    pim_dma_cmd_regs u_cmd_regs (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .capture_i    (capture),
        .funct3_i     (funct3_i),
        .rs1_i        (rs1_i),
        .rs2_i        (rs2_i),
        .load_beats_i (load_beats),
        .advance_i    (advance),
        .cmd_o        (cmd),
        .mem_addr_o   (mem_addr),
        .beats_left_o (beats_left)
    );

    pim_dma_ctrl u_ctrl (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .dma_en_i      (dma_en_i),
        .funct3_i      (funct3_i),
        .bus_gnt_i     (bus_gnt_i),
        .pim_rd_data_i (pim_rd_data_i),
        .cmd_i         (cmd),
        .beats_left_i  (beats_left),
        .phase_o       (phase),
        .capture_o     (capture),
        .load_beats_o  (load_beats),
        .advance_o     (advance),
        .fire_o        (fire),
        .bus_req_o     (bus_req_o),
        .dma_busy_o    (dma_busy_o)
    );

    pim_dma_port_mux u_port_mux (
        .phase_i        (phase),
        .fire_i         (fire),
        .cmd_i          (cmd),
        .mem_addr_i     (mem_addr),
        .beats_left_i   (beats_left),
        .sram_rd_data_i (sram_rd_data_i),
        .pim_rd_data_i  (pim_rd_data_i),
        .sram_o         (sram_o),
        .pim_o          (pim_o)
    );

endmodule

`default_nettype wire

// ==== tb_pim_dma.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "pim_dma_params.svh"

module tb_pim_dma;

    import pim_cmd_pkg::*;
    import pim_bus_pkg::*;

    localparam int TIMEOUT_CYCLES = 2000;
    localparam int SRAM_WORDS     = 1024;

    logic        clk_i = 1'b0;
    logic        rst_ni;
    logic        dma_en_i;
    logic [2:0]  funct3_i;
    logic [31:0] rs1_i;
    logic [31:0] rs2_i;
    logic        bus_gnt_i = 1'b0;
    logic [31:0] sram_rd_data = '0;
    logic [31:0] pim_rd_data = '0;
    logic        bus_req_o;
    logic        dma_busy_o;
    bus_port_t   sram_o;
    bus_port_t   pim_o;

    logic [31:0] sram_mem [SRAM_WORDS];
    bus_port_t   exp_sram_q[$];
    bus_port_t   exp_pim_q[$];
    logic [2:0]  cur_op;
    int          cmd_count;
    int          ready_cmd = -1;
    logic        status_pending = 1'b0;
    int          errors;
    int          timeouts;

    pim_dma_top dut_i (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .dma_en_i       (dma_en_i),
        .funct3_i       (funct3_i),
        .rs1_i          (rs1_i),
        .rs2_i          (rs2_i),
        .bus_req_o      (bus_req_o),
        .bus_gnt_i      (bus_gnt_i),
        .sram_o         (sram_o),
        .sram_rd_data_i (sram_rd_data),
        .pim_o          (pim_o),
        .pim_rd_data_i  (pim_rd_data),
        .dma_busy_o     (dma_busy_o)
    );

    always #5 clk_i = ~clk_i;

    function automatic logic [9:0] sram_index(input logic [31:0] addr);
        return addr[11:2];
    endfunction

    // pim array contents, a mix of every address bit
    function automatic logic [31:0] pim_fill(input logic [31:0] addr);
        return {addr[15:0], addr[31:16]} ^ (addr * 32'h9e37_79b1);
    endfunction

    function automatic bus_port_t port_request(input logic [31:0] addr, input logic we,
                                               input logic [31:0] wdata);
        bus_port_t req;
        req       = '0;
        req.addr  = addr;
        req.we    = we;
        req.re    = !we;
        req.wdata = wdata;
        return req;
    endfunction

    // expected port traffic of one command, status reads left out
    function automatic void expected_transfers(input logic [2:0] op, input logic [31:0] rs1,
                                               input logic [31:0] rs2);
        logic [31:0] row;
        logic [31:0] src;
        row = `PIM_BASE_ADDR + rs1;
        exp_pim_q.push_back(port_request(`PIM_MODE_ADDR, 1'b1, {29'd0, op}));
        case (op)
            ERASE, PROGRAM: begin
                exp_pim_q.push_back(port_request(row, 1'b1, rs2));
            end
            ZP: begin
                exp_pim_q.push_back(port_request(`PIM_ZP_ADDR, 1'b1, rs2));
            end
            READ: begin
                exp_pim_q.push_back(port_request(row, 1'b0, '0));
                exp_sram_q.push_back(port_request(rs2, 1'b1, pim_fill(row)));
            end
            PARALLEL: begin
                for (int k = 0; k < `PIM_PARALLEL_BEATS; k++) begin
                    src = rs2 + 32'(4 * k);
                    exp_sram_q.push_back(port_request(src, 1'b0, '0));
                    exp_pim_q.push_back(port_request(row | (32'(k) << `PIM_BEAT_SHIFT),
                                                     1'b1, sram_mem[sram_index(src)]));
                end
            end
            default: begin
            end
        endcase
    endfunction

    // random grant, roughly 70% high
    always @(posedge clk_i) begin
        bus_gnt_i <= ($urandom_range(99) < 70);
    end

    // sram model, read data held until the next read
    always @(posedge clk_i) begin
        if (sram_o.re) begin
            sram_rd_data <= sram_mem[sram_index(sram_o.addr)];
        end
        if (sram_o.we) begin
            sram_mem[sram_index(sram_o.addr)] <= sram_o.wdata;
        end
    end

    // pim model, status word has random ready bits
    always @(posedge clk_i) begin
        if (pim_o.re) begin
            if (pim_o.addr == `PIM_STATUS_ADDR) begin
                pim_rd_data <= $urandom;
            end else begin
                pim_rd_data <= pim_fill(pim_o.addr);
            end
        end
    end

    task automatic check_transfer(input logic to_pim, input bus_port_t got);
        bus_port_t want;
        string     port;
        logic      outstanding;
        port        = to_pim ? "PIM" : "SRAM";
        outstanding = to_pim ? (exp_pim_q.size() != 0) : (exp_sram_q.size() != 0);
        assert (outstanding) else begin
            errors++;
            $display("Fail at %0t: unexpected %s transfer to address %h with nothing outstanding",
                     $time, port, got.addr);
        end
        if (outstanding) begin
            want = to_pim ? exp_pim_q.pop_front() : exp_sram_q.pop_front();
            assert (got == want) else begin
                errors++;
                $display("Fail at %0t: %s addr %h we %b re %b data %h", $time, port,
                         got.addr, got.we, got.re, got.wdata);
                $display("  expected addr %h we %b re %b data %h",
                         want.addr, want.we, want.re, want.wdata);
            end
        end
    endtask

    // samples the ports of the cycle that ends at this edge
    always @(posedge clk_i) begin
        if (rst_ni) begin
            assert (bus_req_o == dma_busy_o) else begin
                errors++;
                $display("Fail at %0t: bus_req_o %b while dma_busy_o %b", $time,
                         bus_req_o, dma_busy_o);
            end
            assert (bus_gnt_i || (sram_o == '0 && pim_o == '0)) else begin
                errors++;
                $display("Fail at %0t: port driven without grant", $time);
            end
            // status reply shows up one cycle after its read
            if (status_pending && pim_rd_data[0] && (cur_op != READ || pim_rd_data[1])) begin
                ready_cmd = cmd_count;
            end
            status_pending = pim_o.re && (pim_o.addr == `PIM_STATUS_ADDR);
            if (sram_o.re || sram_o.we) begin
                check_transfer(1'b0, sram_o);
            end
            if ((pim_o.re || pim_o.we) && !status_pending) begin
                if (pim_o.we && pim_o.addr == `PIM_MODE_ADDR) begin
                    assert (ready_cmd == cmd_count) else begin
                        errors++;
                        $display("Fail at %0t: mode write for opcode %0d before ready status",
                                 $time, cur_op);
                    end
                end
                check_transfer(1'b1, pim_o);
            end
        end
    end

    task automatic finish_run();
        $display("Checks finished: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    endtask

    task automatic wait_for_done();
        int cycles;
        cycles = 0;
        @(posedge clk_i);
        while (dma_busy_o && cycles < TIMEOUT_CYCLES) begin
            // extra command only in a stalled cycle, so the engine stays busy
            if (!bus_gnt_i && $urandom_range(7) == 0) begin
                dma_en_i <= 1'b1;
                funct3_i <= 3'($urandom_range(7));
                rs1_i    <= $urandom;
                rs2_i    <= $urandom;
            end else begin
                dma_en_i <= 1'b0;
            end
            @(posedge clk_i);
            cycles++;
        end
        dma_en_i <= 1'b0;
        if (dma_busy_o) begin
            $display("Timeout: engine still busy after %0d cycles on opcode %0d",
                     cycles, cur_op);
            timeouts++;
            finish_run();
        end
    endtask

    task automatic run_command(input logic [2:0] op, input logic [31:0] rs1,
                               input logic [31:0] rs2);
        logic supported;
        supported = (op >= 3'd1) && (op <= 3'd5);
        @(posedge clk_i);
        cur_op = op;
        cmd_count++;
        if (supported) begin
            expected_transfers(op, rs1, rs2);
        end
        dma_en_i <= 1'b1;
        funct3_i <= op;
        rs1_i    <= rs1;
        rs2_i    <= rs2;
        @(posedge clk_i);
        dma_en_i <= 1'b0;
        if (supported) begin
            wait_for_done();
        end else begin
            repeat (4) begin
                @(posedge clk_i);
                assert (!dma_busy_o) else begin
                    errors++;
                    $display("Fail at %0t: opcode %0d started the engine", $time, op);
                end
            end
        end
        @(posedge clk_i);
        assert (exp_sram_q.size() == 0 && exp_pim_q.size() == 0) else begin
            errors++;
            $display("Opcode %0d finished with %0d SRAM and %0d PIM transfers missing",
                     op, exp_sram_q.size(), exp_pim_q.size());
            exp_sram_q.delete();
            exp_pim_q.delete();
        end
    endtask

    initial begin
        int i;
        void'($urandom(32'hf53b));
        errors    = 0;
        timeouts  = 0;
        cmd_count = 0;
        cur_op    = '0;
        rst_ni   <= 1'b0;
        dma_en_i <= 1'b0;
        funct3_i <= '0;
        rs1_i    <= '0;
        rs2_i    <= '0;
        for (i = 0; i < SRAM_WORDS; i++) begin
            sram_mem[i] <= $urandom;
        end
        repeat (4) @(posedge clk_i);
        rst_ni <= 1'b1;

        // quiet engine after reset
        repeat (8) begin
            @(posedge clk_i);
            assert (!bus_req_o && !dma_busy_o && !sram_o.re && !sram_o.we &&
                    !pim_o.re && !pim_o.we) else begin
                errors++;
                $display("Fail at %0t: engine active with no command", $time);
            end
        end

        // every opcode once, then a random mix
        for (i = 0; i < 8; i++) begin
            run_command(3'(i), $urandom, $urandom);
        end
        for (i = 0; i < 40; i++) begin
            run_command(3'($urandom_range(7)), $urandom, $urandom);
        end
        finish_run();
    end

endmodule

`default_nettype wire
